//--- hdl/mem_pipe_macros.svh
////////////////////////////////////////
// Width and depth constants for the memory pipeline
// Included by the package and by any RTL that sizes slices
////////////////////////////////////////

`ifndef MEM_PIPE_MACROS_SVH
`define MEM_PIPE_MACROS_SVH

// Data path width
`define MEM_XLEN 32

// Byte address width, 4 KiB window
`define MEM_ADDR_W 12

// Word count follows from the byte address width
`define MEM_DEPTH_WORDS (1 << (`MEM_ADDR_W - 2))

`endif

//--- hdl/mem_pipe_pkg.sv
////////////////////////////////////////
// Shared types for the memory pipeline
// Import with a wildcard in the module header
////////////////////////////////////////

`default_nettype none

`include "mem_pipe_macros.svh"

package mem_pipe_pkg;

    typedef logic [`MEM_XLEN-1:0]     word_t;
    typedef logic [15:0]              halfword_t;
    typedef logic [7:0]               byte_t;
    typedef logic [`MEM_ADDR_W-1:0]   addr_t;
    typedef logic [`MEM_ADDR_W-3:0]   word_addr_t;  // Word index into the RAM
    typedef logic [4:0]               reg_idx_t;
    typedef logic [`MEM_XLEN/8-1:0]   byte_en_t;    // One bit per byte lane

    typedef enum logic [1:0] {
        MEM_OP_NOP,
        MEM_OP_LOAD,
        MEM_OP_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE,
        MEM_SIZE_HALFWORD,
        MEM_SIZE_WORD
    } mem_size_e;

endpackage

`default_nettype wire

//--- hdl/mem_stage1.sv
////////////////////////////////////////
// First memory stage
// Latches the instruction from execute and issues the RAM request
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_pipe_macros.svh"

module mem_stage1
    import mem_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       flush,
    input  logic       in_valid,
    input  mem_op_e    in_mem_op,
    input  mem_size_e  in_mem_size,
    input  logic       in_mem_signed,
    input  addr_t      in_addr,
    input  word_t      in_store_data,
    input  reg_idx_t   in_rd_idx,
    input  logic       in_rd_we,
    output logic       req_en,
    output logic       req_we,
    output word_addr_t req_word_addr,
    output byte_en_t   req_byte_en,
    output word_t      req_wdata,
    output logic       m1_valid,
    output mem_op_e    m1_mem_op,
    output mem_size_e  m1_mem_size,
    output logic       m1_mem_signed,
    output addr_t      m1_addr,
    output word_t      m1_store_data,
    output reg_idx_t   m1_rd_idx,
    output logic       m1_rd_we
);

    logic ff_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (flush) begin
            ff_valid <= 1'b0;                     // Drops whatever arrives too
        end else if (!stall) begin
            ff_valid <= in_valid;
        end
    end

    // Payload, held under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            m1_mem_op     <= in_mem_op;
            m1_mem_size   <= in_mem_size;
            m1_mem_signed <= in_mem_signed;
            m1_addr       <= in_addr;
            m1_store_data <= in_store_data;
            m1_rd_idx     <= in_rd_idx;
            m1_rd_we      <= in_rd_we;
        end
    end

    assign m1_valid = ff_valid && !stall && !flush;  // Nothing advances into M2 otherwise

    // One RAM access per instruction, none while held or flushed
    assign req_en        = m1_valid && (m1_mem_op != MEM_OP_NOP);
    assign req_we        = req_en && (m1_mem_op == MEM_OP_STORE);
    assign req_word_addr = m1_addr[`MEM_ADDR_W-1:2];

    // Lane select and store data replication
    always_comb begin
        case (m1_mem_size)
            MEM_SIZE_BYTE: begin
                req_byte_en = byte_en_t'(4'b0001) << m1_addr[1:0];
                req_wdata   = {4{m1_store_data[7:0]}};
            end
            MEM_SIZE_HALFWORD: begin
                req_byte_en = m1_addr[1] ? 4'b1100 : 4'b0011;  // Aligned pair only
                req_wdata   = {2{m1_store_data[15:0]}};
            end
            default: begin
                req_byte_en = 4'b1111;
                req_wdata   = m1_store_data;
            end
        endcase
    end

    // Execute only hands over naturally aligned accesses
    a_req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        req_en |-> !((m1_mem_size == MEM_SIZE_WORD && m1_addr[1:0] != 2'b00) ||
                     (m1_mem_size == MEM_SIZE_HALFWORD && m1_addr[0])));

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
////////////////////////////////////////
// Byte-writable data RAM
// Write at the request edge, read data one cycle later
// Read register holds its word under stall
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_pipe_macros.svh"

module data_ram
    import mem_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       stall,
    input  logic       req_en,
    input  logic       req_we,
    input  word_addr_t req_word_addr,
    input  byte_en_t   req_byte_en,
    input  word_t      req_wdata,
    output word_t      rsp_rdata
);

    word_t mem [`MEM_DEPTH_WORDS];

    // Start from an all-zero image
    initial begin
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (req_en && req_we) begin
            for (int b = 0; b < `MEM_XLEN / 8; b++) begin
                if (req_byte_en[b]) begin
                    mem[req_word_addr][b*8 +: 8] <= req_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, loads only
    always_ff @(posedge clk) begin
        if (!stall && req_en && !req_we) begin
            rsp_rdata <= mem[req_word_addr];
        end
    end

    // Stage 1 never issues a store with no lanes
    a_we_has_lanes: assert property (@(posedge clk) (req_en && req_we) |-> (req_byte_en != '0));

endmodule

`default_nettype wire

//--- hdl/mem_stage2.sv
////////////////////////////////////////
// Second memory stage
// Aligns and extends load data, drives forwarding and writeback
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_pipe_macros.svh"

module mem_stage2
    import mem_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      flush,
    input  logic      m1_valid,
    input  mem_op_e   m1_mem_op,
    input  mem_size_e m1_mem_size,
    input  logic      m1_mem_signed,
    input  addr_t     m1_addr,
    input  word_t     m1_store_data,
    input  reg_idx_t  m1_rd_idx,
    input  logic      m1_rd_we,
    input  word_t     rsp_rdata,
    output logic      wb_valid,
    output reg_idx_t  wb_rd_idx,
    output logic      wb_rd_we,
    output mem_op_e   wb_mem_op,
    output word_t     wb_alu_result,
    output word_t     wb_mem_rdata,
    output logic      fwd_produces,
    output reg_idx_t  fwd_rd_idx,
    output logic      fwd_val_avail,
    output word_t     fwd_rd_val
);

    logic      ff_valid;
    mem_op_e   ff_mem_op;
    mem_size_e ff_mem_size;
    logic      ff_mem_signed;
    addr_t     ff_addr;
    word_t     ff_store_data;
    reg_idx_t  ff_rd_idx;
    logic      ff_rd_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (flush) begin
            ff_valid <= 1'b0;                     // Also drops a held instruction
        end else if (!stall) begin
            ff_valid <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_mem_op     <= m1_mem_op;
            ff_mem_size   <= m1_mem_size;
            ff_mem_signed <= m1_mem_signed;
            ff_addr       <= m1_addr;
            ff_store_data <= m1_store_data;
            ff_rd_idx     <= m1_rd_idx;
            ff_rd_we      <= m1_rd_we;
        end
    end

    word_t     alu_result;
    halfword_t ld_half;
    byte_t     ld_byte;
    logic      ext_half;
    logic      ext_byte;
    word_t     mem_rdata;

    assign alu_result = word_t'(ff_addr);        // Zero-extended effective address

    // Halfword by bit 1, then byte by bit 0
    always_comb begin
        ld_half  = ff_addr[1] ? rsp_rdata[31:16] : rsp_rdata[15:0];
        ld_byte  = ff_addr[0] ? ld_half[15:8] : ld_half[7:0];
        ext_half = ld_half[15] & ff_mem_signed;
        ext_byte = ld_byte[7] & ff_mem_signed;
        if (ff_mem_op == MEM_OP_LOAD) begin
            case (ff_mem_size)
                MEM_SIZE_BYTE:     mem_rdata = {{(`MEM_XLEN-8){ext_byte}}, ld_byte};
                MEM_SIZE_HALFWORD: mem_rdata = {{(`MEM_XLEN-16){ext_half}}, ld_half};
                default:           mem_rdata = rsp_rdata;
            endcase
        end else if (ff_mem_op == MEM_OP_STORE) begin
            mem_rdata = ff_store_data;            // Stores report the written register
        end else begin
            mem_rdata = rsp_rdata;
        end
    end

    // Forwarder view of the held instruction
    assign fwd_produces  = ff_rd_we && ff_valid;
    assign fwd_rd_idx    = ff_rd_idx;
    assign fwd_val_avail = (ff_mem_op != MEM_OP_LOAD);  // Load data arrives too late
    assign fwd_rd_val    = alu_result;

    // Writeback bundle
    assign wb_valid      = ff_valid && !stall && !flush;
    assign wb_rd_idx     = ff_rd_idx;
    assign wb_rd_we      = ff_rd_we;
    assign wb_mem_op     = ff_mem_op;
    assign wb_alu_result = alu_result;
    assign wb_mem_rdata  = mem_rdata;

    // Stage 1 must gate its valid on the same stall and flush
    a_no_valid_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall || flush) |-> !m1_valid);

endmodule

`default_nettype wire

//--- hdl/mem_pipe_top.sv
////////////////////////////////////////
// Memory subsystem top
// Stage 1, data RAM and stage 2 between execute and writeback
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top
    import mem_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      flush,
    input  logic      in_valid,
    input  mem_op_e   in_mem_op,
    input  mem_size_e in_mem_size,
    input  logic      in_mem_signed,
    input  addr_t     in_addr,          // ALU result
    input  word_t     in_store_data,    // rs2
    input  reg_idx_t  in_rd_idx,
    input  logic      in_rd_we,
    output logic      wb_valid,
    output reg_idx_t  wb_rd_idx,
    output logic      wb_rd_we,
    output mem_op_e   wb_mem_op,
    output word_t     wb_alu_result,
    output word_t     wb_mem_rdata,
    output logic      fwd_produces,
    output reg_idx_t  fwd_rd_idx,
    output logic      fwd_val_avail,
    output word_t     fwd_rd_val
);

    // M1 to M2
    logic      m1_valid;
    mem_op_e   m1_mem_op;
    mem_size_e m1_mem_size;
    logic      m1_mem_signed;
    addr_t     m1_addr;
    word_t     m1_store_data;
    reg_idx_t  m1_rd_idx;
    logic      m1_rd_we;

    // RAM request and response
    logic       req_en;
    logic       req_we;
    word_addr_t req_word_addr;
    byte_en_t   req_byte_en;
    word_t      req_wdata;
    word_t      rsp_rdata;

    mem_stage1 u_stage1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_mem_op     (in_mem_op),
        .in_mem_size   (in_mem_size),
        .in_mem_signed (in_mem_signed),
        .in_addr       (in_addr),
        .in_store_data (in_store_data),
        .in_rd_idx     (in_rd_idx),
        .in_rd_we      (in_rd_we),
        .req_en        (req_en),
        .req_we        (req_we),
        .req_word_addr (req_word_addr),
        .req_byte_en   (req_byte_en),
        .req_wdata     (req_wdata),
        .m1_valid      (m1_valid),
        .m1_mem_op     (m1_mem_op),
        .m1_mem_size   (m1_mem_size),
        .m1_mem_signed (m1_mem_signed),
        .m1_addr       (m1_addr),
        .m1_store_data (m1_store_data),
        .m1_rd_idx     (m1_rd_idx),
        .m1_rd_we      (m1_rd_we)
    );

    data_ram u_ram (
        .clk           (clk),
        .stall         (stall),
        .req_en        (req_en),
        .req_we        (req_we),
        .req_word_addr (req_word_addr),
        .req_byte_en   (req_byte_en),
        .req_wdata     (req_wdata),
        .rsp_rdata     (rsp_rdata)
    );

    mem_stage2 u_stage2 (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .m1_valid      (m1_valid),
        .m1_mem_op     (m1_mem_op),
        .m1_mem_size   (m1_mem_size),
        .m1_mem_signed (m1_mem_signed),
        .m1_addr       (m1_addr),
        .m1_store_data (m1_store_data),
        .m1_rd_idx     (m1_rd_idx),
        .m1_rd_we      (m1_rd_we),
        .rsp_rdata     (rsp_rdata),
        .wb_valid      (wb_valid),
        .wb_rd_idx     (wb_rd_idx),
        .wb_rd_we      (wb_rd_we),
        .wb_mem_op     (wb_mem_op),
        .wb_alu_result (wb_alu_result),
        .wb_mem_rdata  (wb_mem_rdata),
        .fwd_produces  (fwd_produces),
        .fwd_rd_idx    (fwd_rd_idx),
        .fwd_val_avail (fwd_val_avail),
        .fwd_rd_val    (fwd_rd_val)
    );

endmodule

`default_nettype wire

//--- sim/mem_pipe_tb.sv
////////////////////////////////////////
// Testbench for the memory pipeline top
// Replays sim/mem_pipe_trace.txt on falling edges, checks writeback
// and forwarding at rising edges, then adds random NOP fillers
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_pipe_tb
    import mem_pipe_pkg::*;
;

    typedef struct {
        logic [31:0] f[13];                  // Raw trace columns
        string       name;
    } line_t;

    typedef struct {
        string    name;
        reg_idx_t rd;
        logic     rd_we;
        mem_op_e  op;
        word_t    alu;
        word_t    rdata;
        logic     fva;
        int       drive_cycle;
        int       stall_snap;
    } exp_t;

    logic      clk;
    logic      rst_n;
    logic      stall;
    logic      flush;
    logic      in_valid;
    mem_op_e   in_mem_op;
    mem_size_e in_mem_size;
    logic      in_mem_signed;
    addr_t     in_addr;
    word_t     in_store_data;
    reg_idx_t  in_rd_idx;
    logic      in_rd_we;
    logic      wb_valid;
    reg_idx_t  wb_rd_idx;
    logic      wb_rd_we;
    mem_op_e   wb_mem_op;
    word_t     wb_alu_result;
    word_t     wb_mem_rdata;
    logic      fwd_produces;
    reg_idx_t  fwd_rd_idx;
    logic      fwd_val_avail;
    word_t     fwd_rd_val;

    line_t lines[$];
    exp_t  exp_q[$];
    int    cycle       = 0;                   // Rising edges so far
    int    stall_edges = 0;                   // Rising edges seen with stall high
    int    seed        = 32'h6b1c_18d8;
    bit    trace_ready = 0;
    int    limit_cycles;

    mem_pipe_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_op(input string name, input mem_op_e exp, input mem_op_e act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %s, actual %s", name,
                                exp.name(), act.name()));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Trace file into lines, skipping comments and blanks
    task automatic load_trace();
        int    fd;
        int    n;
        int    lineno;
        string text;
        line_t ln;
        fd = $fopen("sim/mem_pipe_trace.txt", "r");
        if (fd == 0) abort_run("could not open the trace file sim/mem_pipe_trace.txt");
        lineno = 0;
        while ($fgets(text, fd) > 0) begin
            lineno++;
            if (text.len() < 2 || text[0] == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        ln.f[0], ln.f[1], ln.f[2], ln.f[3], ln.f[4], ln.f[5], ln.f[6],
                        ln.f[7], ln.f[8], ln.f[9], ln.f[10], ln.f[11], ln.f[12]);
            if (n != 13) abort_run($sformatf("trace line %0d has %0d fields", lineno, n));
            ln.name = $sformatf("trace line %0d", lineno);
            lines.push_back(ln);
        end
        $fclose(fd);
    endtask

    // NOP fillers with random destination, expected values follow directly
    task automatic add_fillers(input int count);
        line_t ln;
        for (int i = 0; i < count; i++) begin
            ln.f[0]  = 1;
            ln.f[1]  = 0;                        // NOP
            ln.f[2]  = 2;
            ln.f[3]  = 0;
            ln.f[4]  = 32'h7f0 + i;
            ln.f[5]  = 0;
            ln.f[6]  = 32'($random(seed)) & 32'h1f;
            ln.f[7]  = 32'($random(seed)) & 32'h1;
            ln.f[8]  = 0;
            ln.f[9]  = 0;
            ln.f[10] = 1;
            ln.f[11] = 0;
            ln.f[12] = 1;                        // Non-loads forward at once
            ln.name  = $sformatf("filler %0d", i);
            lines.push_back(ln);
        end
    endtask

    task automatic drive_line(input line_t ln);
        exp_t e;
        in_valid      = ln.f[0][0];
        in_mem_op     = mem_op_e'(ln.f[1][1:0]);
        in_mem_size   = mem_size_e'(ln.f[2][1:0]);
        in_mem_signed = ln.f[3][0];
        in_addr       = ln.f[4][11:0];
        in_store_data = ln.f[5];
        in_rd_idx     = ln.f[6][4:0];
        in_rd_we      = ln.f[7][0];
        stall         = ln.f[8][0];
        flush         = ln.f[9][0];
        if (ln.f[10][0]) begin
            e.name        = ln.name;
            e.rd          = ln.f[6][4:0];
            e.rd_we       = ln.f[7][0];
            e.op          = mem_op_e'(ln.f[1][1:0]);
            e.alu         = {20'h0, ln.f[4][11:0]};  // ALU result is the address
            e.rdata       = ln.f[11];
            e.fva         = ln.f[12][0];
            e.drive_cycle = cycle;
            e.stall_snap  = stall_edges;
            exp_q.push_back(e);
        end
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_mem_op = MEM_OP_NOP;
        stall = 1'b0;
        flush = 1'b0;
    endtask

    // Stimulus
    initial begin
        rst_n         = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_mem_op     = MEM_OP_NOP;
        in_mem_size   = MEM_SIZE_WORD;
        in_mem_signed = 1'b0;
        in_addr       = '0;
        in_store_data = '0;
        in_rd_idx     = '0;
        in_rd_we      = 1'b0;
        load_trace();
        add_fillers(8);
        limit_cycles = (lines.size() + 10) * 3 + 50;
        trace_ready  = 1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        foreach (lines[i]) begin
            @(negedge clk);
            drive_line(lines[i]);
        end
        repeat (6) begin
            @(negedge clk);
            drive_idle();
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected writebacks never appeared, first is %s",
                                exp_q.size(), exp_q[0].name));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    // Writeback and forwarder monitor, values seen just before the edge
    always @(posedge clk) begin
        exp_t e;
        if (rst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("writeback at cycle %0d with nothing expected", cycle));
            end else begin
                e = exp_q.pop_front();
                check_reg({e.name, " wb_rd_idx"}, e.rd, wb_rd_idx);
                check_bit({e.name, " wb_rd_we"}, e.rd_we, wb_rd_we);
                check_op({e.name, " wb_mem_op"}, e.op, wb_mem_op);
                check_word({e.name, " wb_alu_result"}, e.alu, wb_alu_result);
                if (e.op != MEM_OP_NOP) begin
                    check_word({e.name, " wb_mem_rdata"}, e.rdata, wb_mem_rdata);
                end
                check_bit({e.name, " fwd_produces"}, e.rd_we, fwd_produces);
                check_reg({e.name, " fwd_rd_idx"}, e.rd, fwd_rd_idx);
                check_bit({e.name, " fwd_val_avail"}, e.fva, fwd_val_avail);
                check_word({e.name, " fwd_rd_val"}, e.alu, fwd_rd_val);
                // Two edges after sampling, plus any stalled edges in between
                if (cycle != e.drive_cycle + 2 + (stall_edges - e.stall_snap)) begin
                    abort_run($sformatf("%s came out at cycle %0d, later or earlier than expected",
                                        e.name, cycle));
                end
            end
        end else if (rst_n && !stall && !flush) begin
            // Empty M2, nothing to forward
            check_bit($sformatf("empty M2 at cycle %0d fwd_produces", cycle), 1'b0,
                      fwd_produces);
        end
        if (stall) stall_edges = stall_edges + 1;
        cycle = cycle + 1;
    end

    // Watchdog
    initial begin
        wait (trace_ready);
        repeat (limit_cycles) @(posedge clk);
        abort_run("watchdog expired before the trace finished");
    end

endmodule

`default_nettype wire

//--- sim/mem_pipe_trace.txt
# valid op size signed addr store_data rd_idx rd_we stall flush expect exp_rdata exp_fwd_avail
# op 0 nop 1 load 2 store, size 0 byte 1 half 2 word, all fields hex
0 0 0 0 000 00000000 00 0 0 0 0 00000000 1
1 2 2 0 100 deadbeef 00 0 0 0 1 deadbeef 1
1 1 2 0 100 00000000 05 1 0 0 1 deadbeef 0
1 2 0 0 200 123456a5 00 0 0 0 1 123456a5 1
1 2 0 0 203 00000080 00 0 0 0 1 00000080 1
1 2 1 0 206 0000c3d2 00 0 0 0 1 0000c3d2 1
1 2 1 0 204 abcd1234 00 0 0 0 1 abcd1234 1
1 2 2 0 208 11223344 00 0 0 0 1 11223344 1
1 2 0 0 209 000000ee 00 0 0 0 1 000000ee 1
1 1 0 0 200 00000000 06 1 0 0 1 000000a5 0
1 1 0 1 200 00000000 07 1 0 0 1 ffffffa5 0
1 1 0 1 201 00000000 08 1 0 0 1 00000000 0
1 1 0 0 203 00000000 09 1 0 0 1 00000080 0
1 1 0 1 203 00000000 0a 1 0 0 1 ffffff80 0
1 1 1 0 202 00000000 0b 1 0 0 1 00008000 0
1 1 1 1 202 00000000 0c 1 0 0 1 ffff8000 0
1 1 1 0 206 00000000 0d 1 0 0 1 0000c3d2 0
1 1 1 1 206 00000000 0e 1 0 0 1 ffffc3d2 0
1 1 1 1 204 00000000 0f 1 0 0 1 00001234 0
1 1 2 0 208 00000000 10 1 0 0 1 1122ee44 0
1 1 0 0 209 00000000 11 1 0 0 1 000000ee 0
1 1 0 1 208 00000000 12 1 0 0 1 00000044 0
1 1 1 0 20a 00000000 13 1 0 0 1 00001122 0
1 1 2 0 200 00000000 14 1 0 0 1 800000a5 0
1 0 2 0 3a5 00000000 0a 1 0 0 1 00000000 1
1 0 0 0 7ff 00000000 0b 0 0 0 1 00000000 1
1 2 2 0 300 cafef00d 00 0 0 0 1 cafef00d 1
1 1 2 1 300 00000000 15 1 0 0 1 cafef00d 0
0 0 0 0 000 00000000 00 0 1 0 0 00000000 1
0 0 0 0 000 00000000 00 0 1 0 0 00000000 1
0 0 0 0 000 00000000 00 0 1 0 0 00000000 1
0 0 0 0 000 00000000 00 0 0 0 0 00000000 1
1 2 0 0 304 000000aa 00 0 0 0 1 000000aa 1
0 0 0 0 000 00000000 00 0 1 0 0 00000000 1
0 0 0 0 000 00000000 00 0 1 0 0 00000000 1
1 1 2 0 304 00000000 16 1 0 0 1 000000aa 0
1 0 2 0 0f0 00000000 03 1 0 0 0 00000000 1
1 2 2 0 400 11111111 00 0 0 0 0 11111111 1
1 1 2 0 400 00000000 17 1 0 1 0 00000000 0
1 1 2 0 400 00000000 18 1 0 0 1 00000000 0

//--- build.f
+incdir+hdl
hdl/mem_pipe_pkg.sv
hdl/mem_stage1.sv
hdl/data_ram.sv
hdl/mem_stage2.sv
hdl/mem_pipe_top.sv
sim/mem_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module mem_pipe_tb -o sim_mem_pipe

# The run may end in $fatal, the log decides the result
./obj_dir/sim_mem_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    exit 1
fi
exit 0
